//--- Bender.yml
package:
  name: mem_subsys

export_include_dirs:
  - .

sources:
  # Synthesizable design, in compile order
  - include_dirs:
      - .
    files:
      - mem_pkg.sv
      - sram_sync_1rw.sv
      - stream_fifo.sv
      - mem_bank_ctrl.sv
      - mem_subsys_top.sv

  # Testbench and bound assertions
  - target: simulation
    include_dirs:
      - .
    files:
      - mem_subsys_assertions.sv
      - tb_mem_subsys.sv

//--- mem_bank_ctrl.sv
// ----------------------------
// Bank controller: pops requests, drives one SRAM access per cycle
// and pushes each response into the response queue in order
// ----------------------------

`timescale 1ns/1ns

module mem_bank_ctrl
  import mem_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // Head of the request queue
  input  logic      req_valid,
  output logic      req_ready,
  input  mem_req_t  req,

  // Push side of the response queue
  output logic      resp_valid,
  input  mem_cnt_t  resp_free,
  output mem_resp_t resp,

  // SRAM port, all driven from flops
  output logic      sram_read_en,
  output logic      sram_write_en,
  output mem_addr_t sram_addr,
  output mem_be_t   sram_byte_en,
  output mem_word_t sram_wdata,
  input  mem_word_t sram_rdata
);

  // ------------------------------
  // Pipeline state
  // ------------------------------

  // The issue stage is the registered SRAM command itself
  logic       issue_valid;

  // Completion stage, one entry: the SRAM access has been sampled
  // and its response goes out on the next edge
  logic       cpl_valid;
  logic       cpl_write;

  logic [1:0] in_flight;
  logic       pop;

  assign issue_valid = sram_read_en || sram_write_en;

  // Responses owed but not yet pushed
  assign in_flight = 2'(issue_valid) + 2'(cpl_valid);

  // ------------------------------
  // Issue decision
  // ------------------------------

  // Every request in flight will need a slot, so a new one is only
  // taken when the queue has room for it on top of those
  // The SRAM port is free each cycle since an access takes one cycle
  assign req_ready = (resp_free > mem_cnt_t'(in_flight));
  assign pop       = req_valid && req_ready;

  // Control flops
  // Exactly one enable follows a pop, chosen by the request kind
  always_ff @(posedge clk) begin
    if (reset) begin
      sram_read_en  <= 1'b0;
      sram_write_en <= 1'b0;
      cpl_valid     <= 1'b0;
    end else begin
      sram_read_en  <= pop && !req.is_write;
      sram_write_en <= pop && req.is_write;
      cpl_valid     <= issue_valid;
    end
  end

  // SRAM command payload, only loaded on a pop
  always_ff @(posedge clk) begin
    if (pop) begin
      sram_addr    <= req.addr;
      sram_byte_en <= req.byte_en;
      sram_wdata   <= req.wdata;
    end
  end

  // Kind of the access now completing
  always_ff @(posedge clk) begin
    cpl_write <= sram_write_en;
  end

  // ------------------------------
  // Response push
  // ------------------------------

  // Read data comes straight off the SRAM output register, which
  // holds the word for exactly this cycle
  assign resp_valid    = cpl_valid;
  assign resp.is_write = cpl_write;
  assign resp.rdata    = cpl_write ? '0 : sram_rdata;

endmodule

//--- mem_defines.svh
// ----------------------------
// Sizing macros for the memory subsystem, shared by the package,
// the RTL and the testbench through `include
// ----------------------------

`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// Width of one data word in bits
`define MEM_DATA_W 32

// One byte enable per 8-bit lane of a word
`define MEM_BYTES (`MEM_DATA_W / 8)

// Word address width, which gives 256 words in the bank
`define MEM_ADDR_W 8

// Entries in each of the request and response queues
`define MEM_FIFO_DEPTH 4

`endif

//--- mem_pkg.sv
// ----------------------------
// Shared types for the memory subsystem: field types plus the
// request and response payloads that travel through the queues
// ----------------------------

`include "mem_defines.svh"

package mem_pkg;

  // Scalar field types, sized from the defines header
  typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [`MEM_DATA_W-1:0] mem_word_t;
  typedef logic [`MEM_BYTES-1:0]  mem_be_t;

  // Free-slot count of a queue, wide enough to hold the full depth
  typedef logic [$clog2(`MEM_FIFO_DEPTH + 1)-1:0] mem_cnt_t;

  // One client request
  // Byte enables and write data are ignored for a read
  typedef struct packed {
    logic      is_write;
    mem_addr_t addr;
    mem_be_t   byte_en;
    mem_word_t wdata;
  } mem_req_t;

  // One response per request, returned in request order
  // A write response only acknowledges, so its rdata is zero
  typedef struct packed {
    logic      is_write;
    mem_word_t rdata;
  } mem_resp_t;

endpackage

//--- mem_subsys_assertions.sv
// ----------------------------
// Protocol assertions on the bank controller, attached by bind
// ----------------------------

`timescale 1ns/1ns

module mem_subsys_assertions
  import mem_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input logic     sram_read_en,
  input logic     sram_write_en,
  input logic     resp_valid,
  input mem_cnt_t resp_free
);

  // Running count of failed assertions
  int assert_fails = 0;

  // One port, so a cycle carries a read or a write but never both
  assert property (@(posedge clk) disable iff (reset)
    !(sram_read_en && sram_write_en))
  else begin
    $error("SRAM read and write enables high in the same cycle");
    assert_fails++;
  end

  // The free-slot rule must keep every push away from a full queue
  assert property (@(posedge clk) disable iff (reset)
    resp_valid |-> (resp_free != '0))
  else begin
    $error("Response pushed with no free slot in the response queue");
    assert_fails++;
  end

  // Reset parks the SRAM port
  assert property (@(posedge clk)
    reset |=> (!sram_read_en && !sram_write_en))
  else begin
    $error("SRAM enable high during reset");
    assert_fails++;
  end

endmodule

bind mem_bank_ctrl mem_subsys_assertions u_assertions (
  .clk(clk),
  .reset(reset),
  .sram_read_en(sram_read_en),
  .sram_write_en(sram_write_en),
  .resp_valid(resp_valid),
  .resp_free(resp_free)
);

//--- mem_subsys_top.sv
// ----------------------------
// Memory subsystem top: request queue, bank controller, SRAM and
// response queue behind loose valid/ready client ports
// ----------------------------

`timescale 1ns/1ns

`include "mem_defines.svh"

module mem_subsys_top
  import mem_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // Request channel from the client
  input  logic      req_valid,
  output logic      req_ready,
  input  logic      req_write,
  input  mem_addr_t req_addr,
  input  mem_be_t   req_byte_en,
  input  mem_word_t req_wdata,

  // Response channel back to the client
  output logic      resp_valid,
  input  logic      resp_ready,
  output logic      resp_write,
  output mem_word_t resp_rdata
);

  // Request path
  mem_req_t  req_in;
  mem_req_t  req_head;
  logic      req_head_valid;
  logic      req_head_ready;

  // Response path
  mem_resp_t resp_push;
  logic      resp_push_valid;
  mem_cnt_t  resp_free;
  mem_resp_t resp_out;

  // SRAM port
  logic      sram_read_en;
  logic      sram_write_en;
  mem_addr_t sram_addr;
  mem_be_t   sram_byte_en;
  mem_word_t sram_wdata;
  mem_word_t sram_rdata;

  // Pack the loose client fields for the queue
  assign req_in = '{
    is_write: req_write,
    addr:     req_addr,
    byte_en:  req_byte_en,
    wdata:    req_wdata
  };

  assign resp_write = resp_out.is_write;
  assign resp_rdata = resp_out.rdata;

  // Latency with no stalls is three edges from accept to resp_valid:
  // queue pop, SRAM access, response push

  stream_fifo #(.data_t(mem_req_t), .DEPTH(`MEM_FIFO_DEPTH)) u_req_fifo (
    .clk(clk), .reset(reset),
    .in_valid(req_valid), .in_ready(req_ready), .in_data(req_in),
    .out_valid(req_head_valid), .out_ready(req_head_ready), .out_data(req_head),
    .free_count()
  );

  mem_bank_ctrl u_ctrl (
    .clk(clk), .reset(reset),
    .req_valid(req_head_valid), .req_ready(req_head_ready), .req(req_head),
    .resp_valid(resp_push_valid), .resp_free(resp_free), .resp(resp_push),
    .sram_read_en(sram_read_en), .sram_write_en(sram_write_en),
    .sram_addr(sram_addr), .sram_byte_en(sram_byte_en),
    .sram_wdata(sram_wdata), .sram_rdata(sram_rdata)
  );

  // One shared address serves both sides of the single port
  sram_sync_1rw u_sram (
    .clk(clk), .reset(reset),
    .read_en(sram_read_en), .read_addr(sram_addr), .read_data(sram_rdata),
    .write_en(sram_write_en), .write_byte_en(sram_byte_en),
    .write_addr(sram_addr), .write_data(sram_wdata)
  );

  // in_ready stays open: the controller's free-slot check means a
  // push never meets a full queue
  stream_fifo #(.data_t(mem_resp_t), .DEPTH(`MEM_FIFO_DEPTH)) u_resp_fifo (
    .clk(clk), .reset(reset),
    .in_valid(resp_push_valid), .in_ready(), .in_data(resp_push),
    .out_valid(resp_valid), .out_ready(resp_ready), .out_data(resp_out),
    .free_count(resp_free)
  );

endmodule

//--- sim.f
+incdir+.
mem_pkg.sv
sram_sync_1rw.sv
stream_fifo.sv
mem_bank_ctrl.sv
mem_subsys_top.sv
mem_subsys_assertions.sv
tb_mem_subsys.sv

//--- sram_sync_1rw.sv
// ----------------------------
// Single-port synchronous SRAM with byte-write enables; a read
// returns its word on read_data one edge after it is sampled
// ----------------------------

`timescale 1ns/1ns

`include "mem_defines.svh"

module sram_sync_1rw
  import mem_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // Read side of the shared port
  input  logic      read_en,
  input  mem_addr_t read_addr,
  output mem_word_t read_data,

  // Write side of the shared port, sampled on the rising edge
  input  logic      write_en,
  input  mem_be_t   write_byte_en,
  input  mem_addr_t write_addr,
  input  mem_word_t write_data
);

  localparam int NUM_WORDS = 2 ** `MEM_ADDR_W;

  // Storage array, never cleared, like a real macro
  mem_word_t mem [NUM_WORDS];

  // Registered read
  // Without a read the output goes to X, so nothing downstream
  // can lean on the macro holding its last word
  always_ff @(posedge clk) begin
    if (reset) begin
      read_data <= '0;
    end else if (read_en) begin
      read_data <= mem[read_addr];
    end else begin
      read_data <= 'x;
    end
  end

  // Byte-lane write
  // Each 8-bit lane only changes when its own enable is set
  always_ff @(posedge clk) begin
    if (write_en) begin
      for (int i = 0; i < `MEM_BYTES; i++) begin
        if (write_byte_en[i]) begin
          mem[write_addr][i*8 +: 8] <= write_data[i*8 +: 8];
        end
      end
    end
  end

endmodule

//--- stream_fifo.sv
// ----------------------------
// Valid/ready queue on flip-flops; the payload type is a parameter,
// so one module buffers both requests and responses
// ----------------------------

`timescale 1ns/1ns

`include "mem_defines.svh"

module stream_fifo
  import mem_pkg::*;
#(
  parameter type data_t = mem_req_t,
  parameter int  DEPTH  = `MEM_FIFO_DEPTH
) (
  input  logic                         clk,
  input  logic                         reset,

  // Push side
  input  logic                         in_valid,
  output logic                         in_ready,
  input  data_t                        in_data,

  // Pop side
  output logic                         out_valid,
  input  logic                         out_ready,
  output data_t                        out_data,

  // Slots still free, for a producer that plans ahead
  output logic [$clog2(DEPTH + 1)-1:0] free_count
);

  // ------------------------------
  // Local sizes and state
  // ------------------------------

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Payload entries carry no reset
  data_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Pointer step that also wraps for a depth that is not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  // ------------------------------
  // Handshake
  // ------------------------------

  // Full drops ready and empty drops valid
  // A push and a pop may land on the same edge
  assign in_ready   = (count != CNT_W'(DEPTH));
  assign out_valid  = (count != '0);
  assign push       = in_valid && in_ready;
  assign pop        = out_valid && out_ready;
  assign out_data   = mem[rd_ptr];
  assign free_count = CNT_W'(DEPTH) - count;

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // Occupancy only moves when exactly one side transfers
      case ({push, pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  // An item written here is visible at the head on the next cycle
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

//--- tb_mem_subsys.sv
// ----------------------------
// Self-checking testbench for the memory subsystem
// A stimulus table drives requests and a reference memory predicts every response
// ----------------------------

`timescale 1ns/1ns

`include "mem_defines.svh"

module tb_mem_subsys
  import mem_pkg::*;
();

  // A hold-off this long must back the client up to req_ready low
  localparam int LONG_HOLD = 20;

  // One table row holds a request and the resp_ready hold-off before
  // its response is taken
  typedef struct {
    logic        wr;
    mem_addr_t   addr;
    mem_be_t     be;
    mem_word_t   wdata;
    int unsigned hold;
  } stim_t;

  logic      clk;
  logic      reset;
  logic      req_valid;
  logic      req_ready;
  logic      req_write;
  mem_addr_t req_addr;
  mem_be_t   req_byte_en;
  mem_word_t req_wdata;
  logic      resp_valid;
  logic      resp_ready;
  logic      resp_write;
  mem_word_t resp_rdata;

  stim_t     stim[$];
  mem_word_t ref_mem [2 ** `MEM_ADDR_W];
  logic      exp_write[$];
  mem_word_t exp_rdata[$];

  int value_errors = 0;
  int other_errors = 0;
  int cycle_count  = 0;
  int cycle_limit  = 0;

  mem_subsys_top u_dut (
    .clk(clk), .reset(reset),
    .req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
    .req_addr(req_addr), .req_byte_en(req_byte_en), .req_wdata(req_wdata),
    .resp_valid(resp_valid), .resp_ready(resp_ready),
    .resp_write(resp_write), .resp_rdata(resp_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------
  // Table and reference model
  // ------------------------------

  task automatic add_stim(input logic wr, input mem_addr_t addr, input mem_be_t be,
                          input mem_word_t wdata, input int unsigned hold);
    stim_t s;
    s.wr    = wr;
    s.addr  = addr;
    s.be    = be;
    s.wdata = wdata;
    s.hold  = hold;
    stim.push_back(s);
  endtask

  // Only the lanes whose enable is set take the new byte
  function automatic mem_word_t merge_lanes(input mem_word_t old_word,
                                            input mem_word_t new_word, input mem_be_t be);
    mem_word_t w;
    w = old_word;
    for (int b = 0; b < `MEM_BYTES; b++) begin
      if (be[b]) begin
        w[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return w;
  endfunction

  task automatic build_table();
    mem_addr_t a;
    // Full-word writes, then reads of the same words
    add_stim(1'b1, 8'h00, 4'hf, 32'hdead_beef, 0);
    add_stim(1'b1, 8'h01, 4'hf, 32'h0123_4567, 0);
    add_stim(1'b1, 8'h7f, 4'hf, 32'hcafe_f00d, 0);
    add_stim(1'b1, 8'hff, 4'hf, 32'h89ab_cdef, 0);
    add_stim(1'b0, 8'h00, 4'h0, 32'h0, 0);
    add_stim(1'b0, 8'h01, 4'h0, 32'h0, 0);
    add_stim(1'b0, 8'h7f, 4'h0, 32'h0, 0);
    add_stim(1'b0, 8'hff, 4'h0, 32'h0, 0);
    // Partial writes over a known word
    add_stim(1'b1, 8'h20, 4'hf, 32'haabb_ccdd, 0);
    add_stim(1'b1, 8'h20, 4'b0101, 32'h1122_3344, 0);
    add_stim(1'b0, 8'h20, 4'h0, 32'h0, 0);
    add_stim(1'b1, 8'h20, 4'b1000, 32'h9900_0000, 0);
    add_stim(1'b0, 8'h20, 4'h0, 32'h0, 0);
    // Long response stall with a burst of requests behind it
    add_stim(1'b0, 8'h00, 4'h0, 32'h0, 40);
    for (int k = 0; k < 6; k++) begin
      add_stim(1'b1, 8'h30 + 8'(k), 4'hf, 32'h5a5a_0000 + 32'(k), 0);
      add_stim(1'b0, 8'h30 + 8'(k), 4'h0, 32'h0, 0);
    end
    // Fill the random window so that no read returns an unwritten word
    for (int k = 0; k < 16; k++) begin
      a = 8'h40 + 8'(k);
      add_stim(1'b1, a, 4'hf, {a, ~a, a ^ 8'h5a, 8'h3c}, 0);
    end
    // Random mix with occasional short stalls
    for (int k = 0; k < 200; k++) begin
      add_stim(1'($urandom), 8'h40 + 8'($urandom % 16), 4'($urandom), $urandom,
               (($urandom % 4) == 0) ? ($urandom % 6) : 0);
    end
  endtask

  // The model moves at acceptance, in request order
  task automatic accept_model(input int i);
    if (stim[i].wr) begin
      ref_mem[stim[i].addr] = merge_lanes(ref_mem[stim[i].addr], stim[i].wdata, stim[i].be);
      exp_write.push_back(1'b1);
      exp_rdata.push_back('0);
    end else begin
      exp_write.push_back(1'b0);
      exp_rdata.push_back(ref_mem[stim[i].addr]);
    end
  endtask

  // ------------------------------
  // Request and response sides
  // ------------------------------

  task automatic drive_requests();
    for (int i = 0; i < stim.size(); i++) begin
      req_valid   <= 1'b1;
      req_write   <= stim[i].wr;
      req_addr    <= stim[i].addr;
      req_byte_en <= stim[i].be;
      req_wdata   <= stim[i].wdata;
      @(posedge clk);
      while (!req_ready) @(posedge clk);
      accept_model(i);
    end
    req_valid <= 1'b0;
  endtask

  task automatic check_response(input int n);
    logic      w;
    mem_word_t d;
    if (exp_write.size() == 0) begin
      $display("Response %0d arrived with no request outstanding", n);
      other_errors++;
      return;
    end
    w = exp_write.pop_front();
    d = exp_rdata.pop_front();
    if (resp_write !== w) begin
      $display("[ERROR] resp_write: expected 0x%0h, got 0x%0h (response %0d)", w, resp_write, n);
      value_errors++;
    end
    if (resp_rdata !== d) begin
      $display("[ERROR] resp_rdata: expected 0x%08h, got 0x%08h (response %0d)", d, resp_rdata, n);
      value_errors++;
    end
  endtask

  task automatic collect_responses();
    for (int n = 0; n < stim.size(); n++) begin
      if (stim[n].hold > 0) begin
        resp_ready <= 1'b0;
        repeat (stim[n].hold) @(posedge clk);
        // With the response side blocked this long both queues are full
        if (stim[n].hold >= LONG_HOLD) begin
          if (req_ready !== 1'b0) begin
            $display("[ERROR] req_ready: expected 0x0, got 0x%0h (long stall)", req_ready);
            value_errors++;
          end
        end
      end
      resp_ready <= 1'b1;
      @(posedge clk);
      while (!resp_valid) @(posedge clk);
      check_response(n);
    end
  endtask

  task automatic report_counts();
    $display("Done: %0d requests, %0d value errors, %0d other errors, %0d assertion failures",
             stim.size(), value_errors, other_errors, u_dut.u_ctrl.u_assertions.assert_fails);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin
    reset       = 1'b1;
    req_valid   = 1'b0;
    req_write   = 1'b0;
    req_addr    = '0;
    req_byte_en = '0;
    req_wdata   = '0;
    resp_ready  = 1'b0;
    void'($urandom(37));
    build_table();
    cycle_limit = 20 * stim.size() + 200;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    // Idle state straight out of reset
    if (req_ready !== 1'b1) begin
      $display("[ERROR] req_ready: expected 0x1, got 0x%0h (after reset)", req_ready);
      value_errors++;
    end
    if (resp_valid !== 1'b0) begin
      $display("[ERROR] resp_valid: expected 0x0, got 0x%0h (after reset)", resp_valid);
      value_errors++;
    end
    fork
      drive_requests();
      collect_responses();
    join
    report_counts();
    if (value_errors == 0 && other_errors == 0 &&
        u_dut.u_ctrl.u_assertions.assert_fails == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog on the clock
  initial begin
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    report_counts();
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
